//--- Makefile
VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- sim/fetch_trace.txt
# m <addr> <64-bit word> / r <deliveries> <target> / h <deliveries> <cycles>
# e <expected pc> <expected instruction>, in delivery order
m 80000000 a0000004a0000000
m 80000008 a000000ca0000008
m 80000010 a0000014a0000010
m 80000018 a000001ca0000018
m 80000020 a0000024a0000020
m 80000028 a000002ca0000028
m 80000030 a0000034a0000030
m 80000038 a000003ca0000038
h 2 3
r 4 8000002c
h 7 1
r 9 80000004
h 11 4
e 80000000 a0000000
e 80000004 a0000004
e 80000008 a0000008
e 8000000c a000000c
e 80000010 a0000010
e 8000002c a000002c
e 80000030 a0000030
e 80000034 a0000034
e 80000038 a0000038
e 8000003c a000003c
e 80000004 a0000004
e 80000008 a0000008
e 8000000c a000000c
e 80000010 a0000010

//--- sim/fetch_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_tb import cpu_types_pkg::*, ifetch_bus_pkg::*; ();

	localparam int MAX_EXP = 64;
	localparam int MAX_SCRIPT = 16;
	localparam int WAIT_LIMIT = 200; // cycles allowed per delivery.

	logic       clk;
	logic       rst;
	imem_resp_t imem_resp;
	logic       dec_hold;
	logic       redirect_valid;
	reg_t       redirect_pc;
	imem_req_t  imem_req;
	fetch_out_t fetch_out;
	logic       stall_req;

	reg_t  mem [0:7];
	reg_t  exp_pc [0:MAX_EXP-1];
	inst_t exp_inst [0:MAX_EXP-1];
	int    rd_at [0:MAX_SCRIPT-1];
	reg_t  rd_target [0:MAX_SCRIPT-1];
	int    hd_at [0:MAX_SCRIPT-1];
	int    hd_len [0:MAX_SCRIPT-1];
	int    exp_n;
	int    rd_n;
	int    hd_n;

	int value_errors;
	int proto_errors;
	int timeouts;
	int delivered;
	int hold_left;
	logic first_req_seen;

	// memory model state.
	logic pending; // one address waiting for its data.
	reg_t out_addr;
	int   a_cnt;
	int   d_cnt;
	logic a_rdy;
	logic d_rdy;
	logic [15:0] lfsr = 16'd80;

	fetch_unit dut0 (
		.clk            (clk),
		.rst            (rst),
		.imem_resp      (imem_resp),
		.dec_hold       (dec_hold),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.imem_req       (imem_req),
		.fetch_out      (fetch_out),
		.stall_req      (stall_req)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// a new address is only taken when the outstanding one returns in the same cycle.
	assign d_rdy = (d_cnt == 0);
	assign a_rdy = (a_cnt == 0) && (!pending || d_rdy);
	assign imem_resp.addr_ok = a_rdy;
	assign imem_resp.data_ok = pending ? d_rdy : (d_rdy & imem_req.valid & a_rdy);
	assign imem_resp.data = pending ? mem[out_addr[5:3]] : mem[imem_req.addr[5:3]];

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw_delay(output int d);
		d = 0;
		repeat (2) begin
			d = (d << 1) | lfsr[0]; // one step per bit.
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic read_trace();
		int fd;
		int code;
		string tag;
		string line;
		reg_t a;
		reg_t d;
		int n;
		fd = $fopen("sim/fetch_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file sim/fetch_trace.txt");
			proto_errors++;
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", tag);
			if (code != 1) break;
			if (tag == "m") begin
				code = $fscanf(fd, "%h %h", a, d);
				mem[a[5:3]] = d;
			end else if (tag == "r") begin
				code = $fscanf(fd, "%d %h", n, a);
				rd_at[rd_n] = n;
				rd_target[rd_n] = a;
				rd_n++;
			end else if (tag == "h") begin
				code = $fscanf(fd, "%d %d", hd_at[hd_n], hd_len[hd_n]);
				hd_n++;
			end else if (tag == "e") begin
				code = $fscanf(fd, "%h %h", exp_pc[exp_n], d);
				exp_inst[exp_n] = d[ILEN-1:0];
				exp_n++;
			end else begin
				code = $fgets(line, fd); // comment line.
			end
		end
		$fclose(fd);
	endtask

	task automatic check_delivery();
		reg_t w;
		inst_t half;
		w = mem[fetch_out.pc[5:3]];
		half = fetch_out.pc[2] ? w[63:32] : w[31:0];
		if (delivered < exp_n) begin
			assert (fetch_out.pc == exp_pc[delivered]) else begin
				value_errors++;
				$display("Error: %0d ns: delivery %0d pc %h, expected %h", $time,
					delivered, fetch_out.pc, exp_pc[delivered]);
			end
			assert (fetch_out.inst == exp_inst[delivered] && fetch_out.inst == half) else begin
				value_errors++;
				$display("Error: %0d ns: delivery %0d inst %h, expected %h", $time,
					delivered, fetch_out.inst, exp_inst[delivered]);
			end
		end
	endtask

	always @(posedge clk) begin : monitor
		logic hs;
		logic dok;
		int dly;
		int nd;
		if (rst) begin
			assert (!imem_req.valid && !fetch_out.valid && !stall_req) else begin
				proto_errors++;
				$display("Error: %0d ns: request, delivery or stall during reset", $time);
			end
		end else begin
			hs = imem_req.valid & imem_resp.addr_ok;
			dok = imem_resp.data_ok;
			nd = delivered;
			if (!first_req_seen) begin
				first_req_seen <= 1'b1; // first cycle after reset.
				assert (imem_req.valid && imem_req.addr == exp_pc[0]) else begin
					value_errors++;
					$display("Error: %0d ns: first request after reset valid %b addr %h",
						$time, imem_req.valid, imem_req.addr);
				end
			end
			// a delivery has both handshakes done, a refused address is one missing.
			assert (!(fetch_out.valid && stall_req) &&
				!(imem_req.valid && !imem_resp.addr_ok && !stall_req)) else begin
				proto_errors++;
				$display("Error: %0d ns: stall_req %b with request %b addr_ok %b delivery %b",
					$time, stall_req, imem_req.valid, imem_resp.addr_ok, fetch_out.valid);
			end
			if (pending) begin
				assert (!(hs && !dok)) else begin
					proto_errors++;
					$display("Error: %0d ns: second outstanding address", $time);
				end
				if (hs) begin
					out_addr <= imem_req.addr;
				end else if (dok) begin
					pending <= 1'b0;
				end
			end else if (hs && !dok) begin
				pending <= 1'b1;
				out_addr <= imem_req.addr;
			end
			if (hs) begin
				draw_delay(dly);
				a_cnt <= dly;
			end else if (a_cnt > 0) begin
				a_cnt <= a_cnt - 1;
			end
			if (dok) begin
				draw_delay(dly);
				d_cnt <= dly;
			end else if (d_cnt > 0) begin
				d_cnt <= d_cnt - 1;
			end
			assert (!(dec_hold && fetch_out.valid)) else begin
				proto_errors++;
				$display("Error: %0d ns: valid instruction under decode hold", $time);
			end
			redirect_valid <= 1'b0;
			if (fetch_out.valid && !dec_hold) begin
				check_delivery();
				nd = delivered + 1;
				delivered <= nd;
				for (int i = 0; i < hd_n; i++) begin
					if (hd_at[i] == nd) hold_left = hd_len[i];
				end
				for (int i = 0; i < rd_n; i++) begin
					if (rd_at[i] == nd) begin
						redirect_valid <= 1'b1;
						redirect_pc <= rd_target[i];
						if (hold_left == 0) hold_left = 1; // pulse while nothing issues.
					end
				end
			end
			dec_hold <= (hold_left > 0);
			if (hold_left > 0) hold_left--;
		end
	end

	initial begin
		int waited;
		int seen;
		rst = 1'b1;
		dec_hold = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		pending = 1'b0;
		out_addr = '0;
		a_cnt = 0;
		d_cnt = 0;
		value_errors = 0;
		proto_errors = 0;
		timeouts = 0;
		delivered = 0;
		hold_left = 0;
		first_req_seen = 1'b0;
		exp_n = 0;
		rd_n = 0;
		hd_n = 0;
		read_trace();
		if (exp_n == 0) begin
			$display("the trace holds no expected deliveries");
			proto_errors++;
		end
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		while (delivered < exp_n && timeouts == 0) begin
			waited = 0;
			seen = delivered;
			while (delivered == seen && waited < WAIT_LIMIT) begin
				@(posedge clk);
				waited++;
			end
			if (delivered == seen) begin
				timeouts++;
				$display("timed out waiting for delivery %0d after %0d cycles", seen + 1, waited);
			end
		end
		$display("errors: value %0d, protocol %0d, timeout %0d", value_errors, proto_errors,
			timeouts);
		if (value_errors + proto_errors + timeouts == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- source/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

	localparam int XLEN = 64; // machine word.
	localparam int ILEN = 32; // one uncompressed instruction.

	typedef logic [XLEN-1:0] reg_t;
	typedef logic [ILEN-1:0] inst_t;

	// first fetch address after reset.
	localparam reg_t RESET_PC = 64'h0000_0000_8000_0000;

	// sequential fetch step, one instruction.
	localparam reg_t PC_STEP = 64'd4;

	// selects the upper instruction of a fetched word.
	localparam int PC_HALF_BIT = 2;

	// stall code seen by the fetch stage.
	typedef enum logic [1:0] {
		STALL_NONE = 2'b00, // free to advance.
		STALL_KEEP = 2'b01, // decode holds the current instruction.
		STALL_WAIT = 2'b10  // fetch waits on memory, reported only.
	} stall_t;

endpackage

`default_nettype wire

//--- source/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import cpu_types_pkg::*, ifetch_bus_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  imem_resp_t imem_resp,
	input  logic       dec_hold,
	input  logic       redirect_valid,
	input  reg_t       redirect_pc,
	output imem_req_t  imem_req,
	output fetch_out_t fetch_out,
	output logic       stall_req
);

	reg_t   next_pc;
	reg_t   cur_pc;
	logic   started;
	logic   advance;
	stall_t stall;
	logic   pc_hold;

	pc_gen u_pc_gen (
		.clk            (clk),
		.rst            (rst),
		.cur_pc         (cur_pc),
		.started        (started),
		.advance        (advance),
		.pc_hold        (pc_hold),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.next_pc        (next_pc)
	);

	pipe_ctrl u_pipe_ctrl (
		.dec_hold  (dec_hold),
		.stall_req (stall_req),
		.stall     (stall),
		.pc_hold   (pc_hold)
	);

	if_stage u_if_stage (
		.clk       (clk),
		.rst       (rst),
		.next_pc   (next_pc),
		.stall     (stall),
		.imem_resp (imem_resp),
		.imem_req  (imem_req),
		.cur_pc    (cur_pc),
		.started   (started),
		.advance   (advance),
		.stall_req (stall_req),
		.fetch_out (fetch_out)
	);

endmodule

`default_nettype wire

//--- source/if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module if_stage import cpu_types_pkg::*, ifetch_bus_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  reg_t       next_pc,
	input  stall_t     stall,
	input  imem_resp_t imem_resp,
	output imem_req_t  imem_req,
	output reg_t       cur_pc,
	output logic       started,
	output logic       advance,
	output logic       stall_req,
	output fetch_out_t fetch_out
);

	typedef enum logic [2:0] {
		ST_ISSUE  = 3'b000, // first address after reset.
		ST_WORK   = 3'b001, // pc outstanding, next address offered.
		ST_W_ADDR = 3'b010, // pc data buffered, next address offered.
		ST_W_DATA = 3'b011, // next address taken, pc data missing.
		ST_WAIT   = 3'b100, // like work, after an idle cycle.
		ST_HELD   = 3'b101  // both done, decode holds.
	} fetch_state_t;

	fetch_state_t state;
	fetch_state_t state_nx;

	logic live; // low in the reset cycles.
	reg_t pc;
	reg_t req_pc; // address taken before pc was delivered.
	reg_t data_r;
	reg_t word;

	logic keep;
	logic want_addr;
	logic want_data;
	logic req_valid;
	logic addr_hs;
	logic data_hs;
	logic deliver;
	logic take_next;
	logic take_req;
	logic save_req;
	logic load_buf;

	assign live = ~rst;
	assign keep = (stall == STALL_KEEP);

	assign want_addr = live & (state == ST_ISSUE || state == ST_WORK ||
		state == ST_WAIT || state == ST_W_ADDR);
	assign want_data = (state == ST_WORK || state == ST_WAIT || state == ST_W_DATA);

	assign req_valid = want_addr & ~keep; // no new address under a decode hold.
	assign addr_hs = req_valid & imem_resp.addr_ok;
	assign data_hs = imem_resp.data_ok;

	// fetch is stalled while either handshake is still missing.
	assign stall_req = live & ((state == ST_ISSUE) |
		(want_addr & ~imem_resp.addr_ok) |
		(want_data & ~imem_resp.data_ok));

	always_comb begin
		state_nx  = state;
		deliver   = 1'b0;
		take_next = 1'b0;
		take_req  = 1'b0;
		save_req  = 1'b0;
		load_buf  = 1'b0;
		case (state)
			ST_ISSUE: begin
				if (addr_hs) begin
					take_next = 1'b1;
					load_buf  = data_hs; // zero-latency data.
					state_nx  = data_hs ? ST_W_ADDR : ST_WORK;
				end
			end
			ST_WORK, ST_WAIT: begin
				if (addr_hs && data_hs) begin
					deliver   = 1'b1;
					take_next = 1'b1;
					state_nx  = ST_WORK;
				end else if (data_hs) begin
					load_buf = 1'b1;
					state_nx = ST_W_ADDR;
				end else if (addr_hs) begin
					save_req = 1'b1;
					state_nx = ST_W_DATA;
				end else begin
					state_nx = ST_WAIT;
				end
			end
			ST_W_ADDR: begin
				if (addr_hs) begin
					deliver   = 1'b1;
					take_next = 1'b1;
					// data for the new address may come in the same cycle.
					load_buf  = data_hs;
					state_nx  = data_hs ? ST_W_ADDR : ST_WORK;
				end
			end
			ST_W_DATA: begin
				if (data_hs && !keep) begin
					deliver  = 1'b1;
					take_req = 1'b1;
					state_nx = ST_WORK;
				end else if (data_hs) begin
					load_buf = 1'b1;
					state_nx = ST_HELD;
				end
			end
			ST_HELD: begin
				if (!keep) begin
					deliver  = 1'b1;
					take_req = 1'b1;
					load_buf = data_hs;
					state_nx = data_hs ? ST_W_ADDR : ST_WORK;
				end
			end
			default: begin
				state_nx = ST_ISSUE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_ISSUE;
		end else begin
			state <= state_nx;
		end
	end

	always_ff @(posedge clk) begin
		if (take_next) begin
			pc <= next_pc;
		end else if (take_req) begin
			pc <= req_pc;
		end
		if (save_req) begin
			req_pc <= next_pc;
		end
		if (load_buf) begin
			data_r <= imem_resp.data;
		end
	end

	// buffered states deliver from data_r, the others straight from the bus.
	assign word = (state == ST_W_ADDR || state == ST_HELD) ? data_r : imem_resp.data;

	assign imem_req.valid = req_valid;
	assign imem_req.addr  = next_pc;

	assign fetch_out.valid = deliver;
	assign fetch_out.pc    = pc;
	assign fetch_out.inst  = pc[PC_HALF_BIT] ? word[XLEN-1 -: ILEN] : word[ILEN-1:0];

	assign cur_pc  = pc;
	assign started = (state != ST_ISSUE);
	assign advance = addr_hs;

endmodule

`default_nettype wire

//--- source/ifetch_bus_pkg.sv
`default_nettype none

package ifetch_bus_pkg;

	import cpu_types_pkg::*;

	// address phase towards instruction memory.
	typedef struct packed {
		logic valid; // address offered.
		reg_t addr;  // fetch address.
	} imem_req_t;

	// returns from instruction memory.
	typedef struct packed {
		logic addr_ok; // address taken this cycle.
		logic data_ok; // data of the oldest taken address.
		reg_t data;    // full 64-bit word.
	} imem_resp_t;

	// one instruction handed to decode.
	typedef struct packed {
		logic  valid; // delivered when decode is not holding.
		reg_t  pc;
		inst_t inst;
	} fetch_out_t;

endpackage

`default_nettype wire

//--- source/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pc_gen import cpu_types_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  reg_t cur_pc,
	input  logic started,
	input  logic advance,
	input  logic pc_hold,
	input  logic redirect_valid,
	input  reg_t redirect_pc,
	output reg_t next_pc
);

	logic pend_valid;
	reg_t pend_pc;
	logic pend_clear;

	// the pending target is consumed by the first address issued after it.
	assign pend_clear = advance & started & ~pc_hold;

	always_ff @(posedge clk) begin
		if (rst) begin
			pend_valid <= 1'b0;
		end else if (redirect_valid) begin
			pend_valid <= 1'b1; // newest pulse wins.
		end else if (pend_clear) begin
			pend_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (redirect_valid) begin
			pend_pc <= redirect_pc;
		end
	end

	always_comb begin
		if (!started) begin
			next_pc = RESET_PC;
		end else if (pend_valid) begin
			next_pc = pend_pc;
		end else begin
			next_pc = cur_pc + PC_STEP; // plain sequential fetch.
		end
	end

endmodule

`default_nettype wire

//--- source/pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl import cpu_types_pkg::*; (
	input  logic   dec_hold,
	input  logic   stall_req,
	output stall_t stall,
	output logic   pc_hold
);

	// decode hold has priority over the fetch stage's own wait.
	always_comb begin
		if (dec_hold) begin
			stall = STALL_KEEP;
		end else if (stall_req) begin
			stall = STALL_WAIT; // informational, does not block.
		end else begin
			stall = STALL_NONE;
		end
	end

	// keep a pending redirect while nothing can be issued.
	assign pc_hold = (stall == STALL_KEEP);

endmodule

`default_nettype wire

//--- sources.f
source/cpu_types_pkg.sv
source/ifetch_bus_pkg.sv
source/pc_gen.sv
source/pipe_ctrl.sv
source/if_stage.sv
source/fetch_unit.sv
sim/fetch_unit_tb.sv
